// File: filelist.f
+incdir+tests
source/fetch_pkg.sv
source/branch_queue.sv
source/return_stack.sv
source/fetch_bus_port.sv
source/pc_generate.sv
source/fetch_top.sv
tests/fetch_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the fetch testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f filelist.f --top-module fetch_tb

output=$(./obj_dir/Vfetch_tb)
echo "$output"

if echo "$output" | grep -qx "Simulation passed"; then
	exit 0
else
	exit 1
fi

// File: tests/fetch_tb_tasks.svh
//**********************************************************************
// helpers and directed tests, included inside the testbench module
// every task returns on a rising edge, inputs change by nonblocking
// assignment at that edge, outputs are read there before they update
//**********************************************************************

`ifndef FETCH_TB_TASKS_SVH
`define FETCH_TB_TASKS_SVH

// xorshift32
function automatic logic [31:0] next_random(input logic [31:0] s);
	logic [31:0] x;
	x = s;
	x = x ^ (x << 13);
	x = x ^ (x >> 17);
	x = x ^ (x << 5);
	return x;
endfunction

// OP-IMM word, upper bits fold the whole address, never a jump
function automatic logic [31:0] fill_word(input fetch_pkg::addr_t a);
	logic [24:0] h;
	h = a[24:0] ^ a[49:25] ^ {11'd0, a[63:50]};
	return {h, 7'b0010011};
endfunction

function automatic logic [31:0] mem_word(input fetch_pkg::addr_t a);
	fetch_pkg::addr_t offset;
	offset = a - base;
	if (offset < mem_bytes)
		return mem[offset[9:2]];
	return fill_word(a);
endfunction

// encoders straight from the RV64I formats
function automatic logic [31:0] jal_word(input logic [4:0] rd, input logic [20:0] off);
	return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
endfunction

// beq x0, x0 so only the offset matters
function automatic logic [31:0] branch_word(input logic [12:0] off);
	return {off[12], off[10:5], 5'd0, 5'd0, 3'b000, off[4:1], off[11], 7'b1100011};
endfunction

function automatic logic [31:0] jalr_word(input logic [4:0] rd, input logic [4:0] rs1,
	input logic [11:0] imm);
	return {imm, rs1, 3'b000, rd, 7'b1100111};
endfunction

task automatic load_fill_pattern();
	for (int i = 0; i < mem_words; i++)
		mem[i] = fill_word(base + 64'(i) * 64'd4);
endtask

task automatic put_word(input fetch_pkg::addr_t a, input logic [31:0] w);
	fetch_pkg::addr_t offset;
	offset = a - base;
	mem[offset[9:2]] = w;
endtask

task automatic check_addr(input string what, input fetch_pkg::addr_t expected,
	input fetch_pkg::addr_t actual);
	check_count++;
	if (actual !== expected) begin
		error_count++;
		$display("error %s, %s: expected %h actual %h", current_test, what, expected, actual);
	end
endtask

task automatic check_instr(input string what, input fetch_pkg::rv_instr_t expected,
	input fetch_pkg::rv_instr_t actual);
	check_count++;
	if (actual !== expected) begin
		error_count++;
		$display("error %s, %s: expected %h actual %h", current_test, what, expected, actual);
	end
endtask

task automatic check_bit(input string what, input logic expected, input logic actual);
	check_count++;
	if (actual !== expected) begin
		error_count++;
		$display("error %s, %s: expected %b actual %b", current_test, what, expected, actual);
	end
endtask

// three cycles of reset, all execute inputs idle
task automatic apply_reset();
	@(posedge CLK);
	reset            <= 1'b1;
	jalr_valid       <= 1'b0;
	bru_valid        <= 1'b0;
	bru_taken        <= 1'b0;
	privileged_valid <= 1'b0;
	instr_fifo_full  <= 1'b0;
	repeat (3) @(posedge CLK);
	reset <= 1'b0;
endtask

task automatic grab_outputs();
	snap_valid      = instr_valid;
	snap_pc         = fetch_pc_out;
	snap_instr      = instr_readout;
	snap_mispredict = is_mispredict;
endtask

task automatic next_fetch_is(input string what, input fetch_pkg::addr_t pc,
	input logic [31:0] word);
	int n;
	logic seen;
	n = 0;
	seen = 1'b0;
	while (!seen && n < wait_max) begin
		@(posedge CLK);
		seen = instr_valid;
		n++;
	end
	if (!seen) begin
		error_count++;
		$display("%s, %s: no instruction came out within %0d cycles", current_test, what,
			wait_max);
	end else begin
		check_addr({what, " pc"}, pc, fetch_pc_out);
		check_instr({what, " word"}, word, instr_readout);
	end
endtask

task automatic next_request_is(input string what, input fetch_pkg::addr_t addr);
	int n;
	logic seen;
	n = 0;
	seen = 1'b0;
	while (!seen && n < wait_max) begin
		@(posedge CLK);
		seen = ar_valid;
		n++;
	end
	if (!seen) begin
		error_count++;
		$display("%s, %s: no read request within %0d cycles", current_test, what, wait_max);
	end else begin
		check_addr(what, addr, ar_addr);
	end
endtask

// neither a request nor an instruction may appear
task automatic idle_for(input string what, input int cycles);
	for (int i = 0; i < cycles; i++) begin
		@(posedge CLK);
		check_bit({what, " ar_valid"}, 1'b0, ar_valid);
		check_bit({what, " instr_valid"}, 1'b0, instr_valid);
	end
endtask

// one cycle strobes, outputs captured in the strobe cycle
task automatic give_jalr_target(input fetch_pkg::addr_t target);
	jalr_valid <= 1'b1;
	jalr_pc    <= target;
	@(posedge CLK);
	grab_outputs();
	jalr_valid <= 1'b0;
endtask

task automatic resolve_branch(input logic taken);
	bru_valid <= 1'b1;
	bru_taken <= taken;
	@(posedge CLK);
	grab_outputs();
	bru_valid <= 1'b0;
	bru_taken <= 1'b0;
endtask

task automatic raise_exception(input fetch_pkg::addr_t target);
	privileged_valid <= 1'b1;
	privileged_pc    <= target;
	@(posedge CLK);
	grab_outputs();
	privileged_valid <= 1'b0;
endtask

task automatic reset_and_sequential();
	fetch_pkg::addr_t pc;
	current_test = "sequential";
	load_fill_pattern();
	apply_reset();
	// still in reset on the release edge
	check_bit("ar_valid in reset", 1'b0, ar_valid);
	check_bit("r_ready in reset", 1'b0, r_ready);
	check_bit("instr_valid in reset", 1'b0, instr_valid);
	check_bit("is_mispredict in reset", 1'b0, is_mispredict);
	check_addr("ar_addr in reset", base, ar_addr);
	@(posedge CLK);
	check_bit("ar_valid right after release", 1'b0, ar_valid);
	@(posedge CLK);
	check_bit("first ar_valid", 1'b1, ar_valid);
	check_addr("first ar_addr", base, ar_addr);
	pc = base;
	for (int i = 0; i < 8; i++) begin
		next_fetch_is("straight line", pc, fill_word(pc));
		pc = pc + 64'd4;
		next_request_is("next sequential address", pc);
	end
endtask

task automatic call_and_return();
	fetch_pkg::addr_t target;
	current_test = "call_return";
	target = base + 64'h300;
	load_fill_pattern();
	// jal ra, +16 then ret at the callee end
	put_word(base, jal_word(5'd1, 21'd16));
	put_word(base + 64'd20, jalr_word(5'd0, 5'd1, 12'd0));
	// jalr x0, 0(x6) has no stack entry
	put_word(base + 64'd8, jalr_word(5'd0, 5'd6, 12'd0));
	apply_reset();
	next_request_is("reset vector", base);
	next_fetch_is("jal call", base, jal_word(5'd1, 21'd16));
	next_request_is("jal target", base + 64'd16);
	next_fetch_is("callee", base + 64'd16, fill_word(base + 64'd16));
	next_request_is("callee end", base + 64'd20);
	next_fetch_is("return", base + 64'd20, jalr_word(5'd0, 5'd1, 12'd0));
	next_request_is("return address", base + 64'd4);
	next_fetch_is("after return", base + 64'd4, fill_word(base + 64'd4));
	next_request_is("indirect jalr", base + 64'd8);
	idle_for("jalr without target", 10);
	give_jalr_target(target);
	check_bit("jalr leaves with target", 1'b1, snap_valid);
	check_addr("jalr pc", base + 64'd8, snap_pc);
	check_instr("jalr word", jalr_word(5'd0, 5'd6, 12'd0), snap_instr);
	next_request_is("jalr target", target);
	next_fetch_is("at jalr target", target, fill_word(target));
endtask

task automatic branch_prediction();
	current_test = "branch";
	load_fill_pattern();
	// jal x0 skips ahead, no stack push
	put_word(base, jal_word(5'd0, 21'h40));
	put_word(base + 64'h40, branch_word(13'h20));
	// back to base + 0x20
	put_word(base + 64'h44, branch_word(-13'd36));
	apply_reset();
	next_request_is("reset vector", base);
	next_fetch_is("jal", base, jal_word(5'd0, 21'h40));
	next_request_is("jal target", base + 64'h40);
	next_fetch_is("forward branch", base + 64'h40, branch_word(13'h20));
	next_request_is("forward falls through", base + 64'h44);
	next_fetch_is("backward branch", base + 64'h44, branch_word(-13'd36));
	next_request_is("backward is taken", base + 64'h20);
	// oldest entry predicted not taken
	resolve_branch(1'b0);
	check_bit("agreeing result", 1'b0, snap_mispredict);
	next_fetch_is("backward target", base + 64'h20, fill_word(base + 64'h20));
	next_request_is("after target", base + 64'h24);
	// backward branch was predicted taken
	resolve_branch(1'b0);
	check_bit("disagreeing result", 1'b1, snap_mispredict);
	next_request_is("other path", base + 64'h48);
	next_fetch_is("at other path", base + 64'h48, fill_word(base + 64'h48));
endtask

task automatic exception_redirect();
	fetch_pkg::addr_t target;
	current_test = "exception";
	target = base + 64'h200;
	load_fill_pattern();
	// stale word stands out if it leaks
	put_word(base + 64'd4, jal_word(5'd0, 21'h100));
	apply_reset();
	next_request_is("reset vector", base);
	next_fetch_is("first word", base, fill_word(base));
	next_request_is("pending request", base + 64'd4);
	raise_exception(target);
	check_bit("no word in exception cycle", 1'b0, snap_valid);
	next_request_is("exception target", target);
	next_fetch_is("at exception target", target, fill_word(target));
endtask

task automatic fifo_backpressure();
	current_test = "fifo_full";
	load_fill_pattern();
	apply_reset();
	next_request_is("reset vector", base);
	next_fetch_is("first word", base, fill_word(base));
	next_request_is("second request", base + 64'd4);
	instr_fifo_full <= 1'b1;
	idle_for("fifo full", 12);
	instr_fifo_full <= 1'b0;
	next_fetch_is("after fifo drains", base + 64'd4, fill_word(base + 64'd4));
	next_request_is("fetch resumes", base + 64'd8);
endtask

task automatic queue_full_stall();
	current_test = "queue_full";
	load_fill_pattern();
	// two word loop, one prediction per turn
	put_word(base + 64'd4, branch_word(-13'd4));
	apply_reset();
	for (int i = 0; i < 16; i++) begin
		next_request_is("loop top", base);
		next_fetch_is("loop body", base, fill_word(base));
		next_request_is("loop branch", base + 64'd4);
		next_fetch_is("loop branch", base + 64'd4, branch_word(-13'd4));
	end
	next_request_is("loop top with full queue", base);
	next_fetch_is("loop body with full queue", base, fill_word(base));
	next_request_is("branch with full queue", base + 64'd4);
	idle_for("queue full", 12);
	resolve_branch(1'b1);
	check_bit("agreeing result", 1'b0, snap_mispredict);
	check_bit("held while full", 1'b0, snap_valid);
	next_fetch_is("branch after pop", base + 64'd4, branch_word(-13'd4));
	next_request_is("loop continues", base);
endtask

`endif

// File: tests/fetch_tb.sv
//**********************************************************************
// testbench for the RV64I fetch front end
// bus memory answers each read after 1 to 3 cycles, one at a time
// memory window is 1 KiB from the reset vector, other addresses read
// the address dependent fill pattern
//**********************************************************************

`timescale 1ns/1ps

module fetch_tb;

	localparam int clk_period = 20;
	// longest wait for any single handshake
	localparam int wait_max = 16;
	localparam int mem_words = 256;
	localparam fetch_pkg::addr_t mem_bytes = 64'd1024;
	localparam fetch_pkg::addr_t base = fetch_pkg::reset_vector;
	// rough length of each test in cycles, in run order
	localparam int test_cycles = 80 + 120 + 140 + 70 + 70 + 300;
	localparam int watchdog_cycles = test_cycles * 4;

	logic                 CLK = 1'b0;
	logic                 reset;
	logic                 jalr_valid;
	fetch_pkg::addr_t     jalr_pc;
	logic                 bru_valid;
	logic                 bru_taken;
	logic                 privileged_valid;
	fetch_pkg::addr_t     privileged_pc;
	logic                 instr_fifo_full;
	fetch_pkg::addr_t     ar_addr;
	logic                 ar_valid;
	logic                 r_ready;
	logic                 r_valid = 1'b0;
	fetch_pkg::rv_instr_t r_data = '0;
	logic                 is_mispredict;
	logic                 instr_valid;
	fetch_pkg::rv_instr_t instr_readout;
	fetch_pkg::addr_t     fetch_pc_out;

	// bus memory model state
	logic [31:0]      mem [mem_words];
	logic             mem_busy = 1'b0;
	logic [1:0]       mem_wait = 2'd0;
	fetch_pkg::addr_t mem_addr = '0;
	logic [31:0]      rng_state = 32'haefa_32cc;

	string current_test;
	int    error_count;
	int    check_count;

	// outputs captured at the end of a strobe cycle
	logic                 snap_valid;
	fetch_pkg::addr_t     snap_pc;
	fetch_pkg::rv_instr_t snap_instr;
	logic                 snap_mispredict;

	`include "fetch_tb_tasks.svh"

	always #(clk_period / 2) CLK = ~CLK;

	fetch_top UUT (
		.CLK              (CLK),
		.reset            (reset),
		.jalr_valid       (jalr_valid),
		.jalr_pc          (jalr_pc),
		.bru_valid        (bru_valid),
		.bru_taken        (bru_taken),
		.privileged_valid (privileged_valid),
		.privileged_pc    (privileged_pc),
		.instr_fifo_full  (instr_fifo_full),
		.ar_addr          (ar_addr),
		.ar_valid         (ar_valid),
		.r_ready          (r_ready),
		.r_valid          (r_valid),
		.r_data           (r_data),
		.is_mispredict    (is_mispredict),
		.instr_valid      (instr_valid),
		.instr_readout    (instr_readout),
		.fetch_pc_out     (fetch_pc_out)
	);

	// memory model, random latency per request
	always @(posedge CLK) begin
		if (reset) begin
			r_valid  <= 1'b0;
			mem_busy <= 1'b0;
		end else if (r_valid && r_ready) begin
			r_valid <= 1'b0;
		end else if (mem_busy) begin
			if (mem_wait == 2'd0) begin
				r_valid  <= 1'b1;
				r_data   <= mem_word(mem_addr);
				mem_busy <= 1'b0;
			end else begin
				mem_wait <= mem_wait - 2'd1;
			end
		end
		// new request, latency of mem_wait + 1 cycles
		if (!reset && ar_valid) begin
			mem_busy  <= 1'b1;
			mem_addr  <= ar_addr;
			mem_wait  <= 2'(rng_state % 3);
			rng_state <= next_random(rng_state);
		end
	end

	initial begin
		reset            = 1'b1;
		jalr_valid       = 1'b0;
		jalr_pc          = '0;
		bru_valid        = 1'b0;
		bru_taken        = 1'b0;
		privileged_valid = 1'b0;
		privileged_pc    = '0;
		instr_fifo_full  = 1'b0;
		error_count      = 0;
		check_count      = 0;
		reset_and_sequential();
		call_and_return();
		branch_prediction();
		exception_redirect();
		fifo_backpressure();
		queue_full_stall();
		$display("checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// watchdog
	initial begin
		#(watchdog_cycles * clk_period);
		$display("watchdog expired after %0d cycles in test %s", watchdog_cycles,
			current_test);
		$display("checks: %0d, errors: %0d", check_count, error_count);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: source/fetch_top.sv
//**********************************************************************
// fetch front end top, generator plus bus port
// execute results arrive as single cycle strobes
//**********************************************************************

`timescale 1ns/1ps

module fetch_top (
	input  logic                 CLK,
	input  logic                 reset,
	input  logic                 jalr_valid,
	input  fetch_pkg::addr_t     jalr_pc,
	input  logic                 bru_valid,
	input  logic                 bru_taken,
	input  logic                 privileged_valid,
	input  fetch_pkg::addr_t     privileged_pc,
	input  logic                 instr_fifo_full,
	output fetch_pkg::addr_t     ar_addr,
	output logic                 ar_valid,
	output logic                 r_ready,
	input  logic                 r_valid,
	input  fetch_pkg::rv_instr_t r_data,
	output logic                 is_mispredict,
	output logic                 instr_valid,
	output fetch_pkg::rv_instr_t instr_readout,
	output fetch_pkg::addr_t     fetch_pc_out
);

	logic                 fetch_valid;
	logic                 redirect;
	logic                 instr_held;
	fetch_pkg::addr_t     fetch_pc_next;
	fetch_pkg::addr_t     fetch_pc;
	fetch_pkg::rv_instr_t instr;

	pc_generate u_pc_generate (
		.CLK              (CLK),
		.reset            (reset),
		.jalr_valid       (jalr_valid),
		.jalr_pc          (jalr_pc),
		.bru_valid        (bru_valid),
		.bru_taken        (bru_taken),
		.privileged_valid (privileged_valid),
		.privileged_pc    (privileged_pc),
		.instr_fifo_full  (instr_fifo_full),
		.fetch_pc         (fetch_pc),
		.instr            (instr),
		.instr_held       (instr_held),
		.fetch_valid      (fetch_valid),
		.fetch_pc_next    (fetch_pc_next),
		.redirect         (redirect),
		.is_mispredict    (is_mispredict),
		.instr_valid      (instr_valid),
		.instr_readout    (instr_readout),
		.fetch_pc_out     (fetch_pc_out)
	);

	fetch_bus_port u_fetch_bus_port (
		.CLK           (CLK),
		.reset         (reset),
		.fetch_valid   (fetch_valid),
		.fetch_pc_next (fetch_pc_next),
		.redirect      (redirect),
		.ar_addr       (ar_addr),
		.ar_valid      (ar_valid),
		.r_ready       (r_ready),
		.r_valid       (r_valid),
		.r_data        (r_data),
		.fetch_pc      (fetch_pc),
		.instr         (instr),
		.instr_held    (instr_held)
	);

endmodule

// File: source/pc_generate.sv
//**********************************************************************
// fetch address generator with static prediction
// backward branches taken, forward not, every jal and jalr taken
// a jalr missing the return stack waits for its target from execute
// any redirect flushes both the branch queue and the return stack
//**********************************************************************

`timescale 1ns/1ps

module pc_generate (
	input  logic                 CLK,
	input  logic                 reset,
	input  logic                 jalr_valid,
	input  fetch_pkg::addr_t     jalr_pc,
	input  logic                 bru_valid,
	input  logic                 bru_taken,
	input  logic                 privileged_valid,
	input  fetch_pkg::addr_t     privileged_pc,
	input  logic                 instr_fifo_full,
	input  fetch_pkg::addr_t     fetch_pc,
	input  fetch_pkg::rv_instr_t instr,
	input  logic                 instr_held,
	output logic                 fetch_valid,
	output fetch_pkg::addr_t     fetch_pc_next,
	output logic                 redirect,
	output logic                 is_mispredict,
	output logic                 instr_valid,
	output fetch_pkg::rv_instr_t instr_readout,
	output fetch_pkg::addr_t     fetch_pc_out
);

	logic                 is_jal;
	logic                 is_jalr;
	logic                 is_branch;
	logic                 is_call;
	logic                 is_return;
	logic                 pred_taken;
	fetch_pkg::addr_t     imm;
	fetch_pkg::addr_t     pc_plus4;
	fetch_pkg::addr_t     branch_target;
	fetch_pkg::addr_t     pred_target;
	logic                 ras_hit;
	logic                 ras_empty;
	fetch_pkg::addr_t     ras_top;
	logic                 bq_full;
	logic                 bq_push;
	fetch_pkg::bq_entry_t bq_push_entry;
	fetch_pkg::bq_entry_t bq_head;
	logic                 bq_stall;
	logic                 jalr_stall;
	logic                 stall;
	logic                 run;
	logic                 advance;

	function automatic logic is_link_reg(input logic [4:0] r);
		return (r == fetch_pkg::link_reg_ra) || (r == fetch_pkg::link_reg_t0);
	endfunction

	// opcode decode, each through its own format
	assign is_jal = (instr.j_fmt.opcode == fetch_pkg::op_jal);
	assign is_jalr = (instr.i_fmt.opcode == fetch_pkg::op_jalr);
	assign is_branch = (instr.b_fmt.opcode == fetch_pkg::op_branch);

	assign is_call = (is_jal & is_link_reg(instr.j_fmt.rd))
		| (is_jalr & is_link_reg(instr.i_fmt.rd));
	// rs1 == rd is a push only, not a return
	assign is_return = is_jalr & is_link_reg(instr.i_fmt.rs1)
		& (instr.i_fmt.rs1 != instr.i_fmt.rd);

	// jalr target comes from the stack or execute, so no jalr offset here
	always_comb begin
		imm = '0;
		if (is_jal)
			imm = {{44{instr.j_fmt.imm20}}, instr.j_fmt.imm19_12, instr.j_fmt.imm11,
				instr.j_fmt.imm10_1, 1'b0};
		else if (is_branch)
			imm = {{52{instr.b_fmt.imm12}}, instr.b_fmt.imm11, instr.b_fmt.imm10_5,
				instr.b_fmt.imm4_1, 1'b0};
	end

	// negative offset means backward branch
	assign pred_taken = (is_branch & imm[63]) | is_jal | is_jalr;

	assign pc_plus4 = fetch_pc + 64'd4;
	assign branch_target = fetch_pc + imm;
	assign ras_hit = is_return & ~ras_empty;
	assign pred_target = is_jalr ? (ras_hit ? ras_top : jalr_pc) : branch_target;

	// branch unit result against the oldest prediction
	assign is_mispredict = bru_valid & (bru_taken ^ bq_head.taken);
	assign redirect = is_mispredict | privileged_valid;

	assign bq_stall = is_branch & bq_full;
	assign jalr_stall = is_jalr & ~ras_hit & ~jalr_valid;
	assign stall = bq_stall | jalr_stall | instr_fifo_full;

	assign run = instr_held & ~stall;
	assign fetch_valid = run | redirect;
	// word leaves only without a redirect
	assign advance = run & ~redirect;

	always_comb begin
		if (privileged_valid)
			fetch_pc_next = privileged_pc;
		else if (is_mispredict)
			fetch_pc_next = bq_head.alt_addr;
		else if (stall)
			fetch_pc_next = fetch_pc;
		else if (pred_taken)
			fetch_pc_next = pred_target;
		else
			fetch_pc_next = pc_plus4;
	end

	assign instr_valid = advance;
	assign instr_readout = instr;
	assign fetch_pc_out = fetch_pc;

	// remember the path not taken
	assign bq_push = advance & is_branch;
	assign bq_push_entry.taken = pred_taken;
	assign bq_push_entry.alt_addr = pred_taken ? pc_plus4 : branch_target;

	branch_queue u_branch_queue (
		.CLK        (CLK),
		.reset      (reset),
		.flush      (redirect),
		.push       (bq_push),
		.push_entry (bq_push_entry),
		.pop        (bru_valid),
		.head_entry (bq_head),
		.full       (bq_full)
	);

	return_stack u_return_stack (
		.CLK       (CLK),
		.reset     (reset),
		.flush     (redirect),
		.push      (advance & is_call),
		.push_addr (pc_plus4),
		.pop       (advance & ras_hit),
		.top_addr  (ras_top),
		.empty     (ras_empty)
	);

endmodule

// File: source/fetch_bus_port.sv
//**********************************************************************
// instruction read port, one request outstanding at a time
// ar_valid is a single cycle pulse, r_ready stays high while waiting
// a redirect during a request discards the late response
//**********************************************************************

`timescale 1ns/1ps

module fetch_bus_port (
	input  logic                 CLK,
	input  logic                 reset,
	input  logic                 fetch_valid,
	input  fetch_pkg::addr_t     fetch_pc_next,
	input  logic                 redirect,
	output fetch_pkg::addr_t     ar_addr,
	output logic                 ar_valid,
	output logic                 r_ready,
	input  logic                 r_valid,
	input  fetch_pkg::rv_instr_t r_data,
	output fetch_pkg::addr_t     fetch_pc,
	output fetch_pkg::rv_instr_t instr,
	output logic                 instr_held
);

	logic [1:0] state;
	logic       discard;
	logic       r_fire;

	assign ar_addr = fetch_pc;
	assign r_ready = (state == fetch_pkg::bus_st_wait);
	assign r_fire = r_valid & r_ready;
	assign instr_held = (state == fetch_pkg::bus_st_hold);

	// held word, no reset needed
	always_ff @(posedge CLK) begin
		if (r_fire && !discard && !redirect)
			instr <= r_data;
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			state    <= fetch_pkg::bus_st_issue;
			ar_valid <= 1'b0;
			discard  <= 1'b0;
			fetch_pc <= fetch_pkg::reset_vector;
		end else begin
			case (state)
				fetch_pkg::bus_st_issue: begin
					if (redirect)
						fetch_pc <= fetch_pc_next;
					if (ar_valid) begin
						// request is out this cycle
						state    <= fetch_pkg::bus_st_wait;
						ar_valid <= 1'b0;
						discard  <= redirect;
					end else begin
						// first cycle after reset
						ar_valid <= 1'b1;
					end
				end
				fetch_pkg::bus_st_wait: begin
					if (redirect)
						fetch_pc <= fetch_pc_next;
					if (r_fire) begin
						discard <= 1'b0;
						if (discard || redirect) begin
							// stale word, refetch at latched address
							state    <= fetch_pkg::bus_st_issue;
							ar_valid <= 1'b1;
						end else begin
							state <= fetch_pkg::bus_st_hold;
						end
					end else if (redirect) begin
						discard <= 1'b1;
					end
				end
				default: begin
					// hold until the generator lets the word go
					if (fetch_valid) begin
						fetch_pc <= fetch_pc_next;
						state    <= fetch_pkg::bus_st_issue;
						ar_valid <= 1'b1;
					end
				end
			endcase
		end
	end

endmodule

// File: source/return_stack.sv
//**********************************************************************
// wrapping return address stack
// on overflow the oldest entry is lost, never the newest
// popping an empty stack does nothing, callers check empty first
//**********************************************************************

`timescale 1ns/1ps

module return_stack (
	input  logic             CLK,
	input  logic             reset,
	input  logic             flush,
	input  logic             push,
	input  fetch_pkg::addr_t push_addr,
	input  logic             pop,
	output fetch_pkg::addr_t top_addr,
	output logic             empty
);

	fetch_pkg::addr_t stack_mem [fetch_pkg::ras_depth];

	// wr_ptr is the next free slot, top sits one below it
	logic [fetch_pkg::ras_idx_w-1:0] wr_ptr;
	logic [fetch_pkg::ras_idx_w-1:0] top_ptr;
	logic [fetch_pkg::ras_idx_w:0]   fill;
	logic                            fill_max;

	assign top_ptr = wr_ptr - 1'b1;
	assign top_addr = stack_mem[top_ptr];
	assign empty = (fill == '0);
	assign fill_max = (fill == (fetch_pkg::ras_idx_w+1)'(fetch_pkg::ras_depth));

	always_ff @(posedge CLK) begin
		// push with pop swaps the top in place
		if (push && pop)
			stack_mem[top_ptr] <= push_addr;
		else if (push)
			stack_mem[wr_ptr] <= push_addr;
	end

	always_ff @(posedge CLK) begin
		if (reset || flush) begin
			wr_ptr <= '0;
			fill   <= '0;
		end else if (push && !pop) begin
			// pointer wraps onto the oldest slot when full
			wr_ptr <= wr_ptr + 1'b1;
			if (!fill_max)
				fill <= fill + 1'b1;
		end else if (pop && !push && !empty) begin
			wr_ptr <= top_ptr;
			fill   <= fill - 1'b1;
		end
	end

endmodule

// File: source/branch_queue.sv
//**********************************************************************
// in-order queue of unresolved branch predictions
// push while full and pop while empty are ignored
// flush wins over push and pop in the same cycle
//**********************************************************************

`timescale 1ns/1ps

module branch_queue (
	input  logic                 CLK,
	input  logic                 reset,
	input  logic                 flush,
	input  logic                 push,
	input  fetch_pkg::bq_entry_t push_entry,
	input  logic                 pop,
	output fetch_pkg::bq_entry_t head_entry,
	output logic                 full
);

	fetch_pkg::bq_entry_t queue_mem [fetch_pkg::bq_depth];

	logic [fetch_pkg::bq_idx_w-1:0] rd_ptr;
	logic [fetch_pkg::bq_idx_w-1:0] wr_ptr;
	logic [fetch_pkg::bq_idx_w:0]   count;
	logic                           do_push;
	logic                           do_pop;

	assign full = (count == (fetch_pkg::bq_idx_w+1)'(fetch_pkg::bq_depth));
	assign do_push = push & ~full;
	assign do_pop = pop & (count != '0);

	// oldest prediction, compared against the branch unit result
	assign head_entry = queue_mem[rd_ptr];

	// payload only, no reset
	always_ff @(posedge CLK) begin
		if (do_push)
			queue_mem[wr_ptr] <= push_entry;
	end

	always_ff @(posedge CLK) begin
		if (reset || flush) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			// simultaneous push and pop keeps the count
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

endmodule

// File: source/fetch_pkg.sv
//**********************************************************************
// shared types and constants for the RV64I fetch front end
// no compressed instructions, so every fetch word is 32 bits at pc+4
// queue and stack depths must stay powers of two
//**********************************************************************

package fetch_pkg;

	// instruction address
	typedef logic [63:0] addr_t;

	// jal layout
	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	// conditional branch layout
	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	// jalr layout, plain I-type
	typedef struct packed {
		logic [11:0] imm12;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	// one fetched word, read in whichever format the opcode implies
	typedef union packed {
		j_fmt_t j_fmt;
		b_fmt_t b_fmt;
		i_fmt_t i_fmt;
	} rv_instr_t;

	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_jalr   = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;

	localparam addr_t reset_vector = 64'h0000_0000_8000_0000;

	// link registers per the calling convention hint table
	localparam logic [4:0] link_reg_ra = 5'd1;
	localparam logic [4:0] link_reg_t0 = 5'd5;

	localparam int bq_depth  = 16;
	localparam int bq_idx_w  = 4;
	localparam int ras_depth = 16;
	localparam int ras_idx_w = 4;

	// bus port controller states
	localparam logic [1:0] bus_st_issue = 2'd0;
	localparam logic [1:0] bus_st_wait  = 2'd1;
	localparam logic [1:0] bus_st_hold  = 2'd2;

	// one unresolved prediction
	typedef struct packed {
		logic  taken;
		addr_t alt_addr;
	} bq_entry_t;

endpackage
